//--- rtl/fetch_mux_pkg.sv
// ====================================================================
// Shared widths, opcodes and pipeline-slot types for the fetch mux
// stage. Every RTL module and the testbench pull these in with a
// wildcard import.
// ====================================================================

package fetch_mux_pkg;

	// ====================================================================
	// Widths and constants
	// ====================================================================

	// Instructions handed to decode per cycle
	localparam int NUM_SLOTS = 4;

	// Instructions are built from 16-bit parcels
	localparam int PARCEL_BITS = 16;

	// Every instruction is three parcels long, so six bytes
	localparam int INSN_PARCELS = 3;
	localparam int INSN_BYTES = 6;

	// A 64-byte instruction-cache line
	localparam int LINE_BITS = 512;

	// ====================================================================
	// Vector types
	// ====================================================================

	// Byte address of an instruction
	typedef logic [31:0] pc_t;

	// Opcode in bits 6:0, displacement in bits 47:16
	typedef logic [INSN_PARCELS*PARCEL_BITS-1:0] insn_t;

	// Raw cache line from the fetch stage
	typedef logic [LINE_BITS-1:0] line_t;

	// The part of the line that covers one group once it is aligned
	typedef logic [NUM_SLOTS*INSN_PARCELS*PARCEL_BITS-1:0] aligned_t;

	typedef logic [6:0] opcode_t;

	// ====================================================================
	// Opcodes
	// ====================================================================

	// NOP is zero so that zero-filled padding decodes as a NOP as well
	localparam opcode_t OP_NOP = 7'h00;
	// PC-relative call
	localparam opcode_t OP_BSR = 7'h01;
	// PC-relative branch
	localparam opcode_t OP_BRA = 7'h02;
	// Absolute call, the displacement field is the target
	localparam opcode_t OP_JSR = 7'h03;
	// Call through a register, the target is not known here
	localparam opcode_t OP_JSRR = 7'h04;
	localparam opcode_t OP_RET = 7'h05;

	// A full 48-bit NOP with every field other than the opcode zero
	localparam insn_t NOP_INSN = insn_t'(OP_NOP);

	// ====================================================================
	// Slot and flow structs
	// ====================================================================

	// One instruction slot in the pipeline group
	typedef struct packed {
		logic valid;
		// Suppressed by single stepping
		logic ssm;
		pc_t pc;
		insn_t insn;
	} slot_t;

	// Slot 0 is the oldest instruction of the group
	typedef slot_t [NUM_SLOTS-1:0] group_t;

	// Result of the flow-change scan over a registered group
	typedef struct packed {
		logic do_branch;
		logic do_call;
		logic do_ret;
		pc_t tgt;
		pc_t ret_pc;
	} flow_t;

endpackage

//--- rtl/line_aligner.sv
// ====================================================================
// Aligns a fetched cache line at the parcel addressed by the fetch PC
// and flags a group that repeats the last fetch advance.
// ====================================================================

`timescale 1ns/1ns

module line_aligner import fetch_mux_pkg::*; (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     advance_fet_i,
	input  line_t    line_i,
	input  pc_t      pc_i,
	output aligned_t aligned_o,
	output logic     redundant_o
);

	// A NOP in a single parcel, used to pad past the end of the line
	localparam logic [PARCEL_BITS-1:0] NOP_PARCEL = PARCEL_BITS'(OP_NOP);

	// Enough padding parcels to fill a whole group above the line
	localparam int PAD_PARCELS = NUM_SLOTS * INSN_PARCELS;

	localparam int EXT_BITS = PAD_PARCELS * PARCEL_BITS + LINE_BITS;

	// Line with NOP parcels stacked on top of it
	logic [EXT_BITS-1:0] line_ext;

	// Shift amount in bits, the parcel index times sixteen
	logic [8:0] shamt;

	// Fetch PC and aligned line from the last advance
	pc_t      prev_pc;
	aligned_t prev_aligned;

	// ====================================================================
	// Alignment
	// ====================================================================

	always_comb begin
		line_ext = {{PAD_PARCELS{NOP_PARCEL}}, line_i};
		// PC bits 5:1 select one of the 32 parcels in a 64-byte line
		shamt = {pc_i[5:1], 4'd0};
	end

	// Only the low end of the shifted line is needed for four slots
	assign aligned_o = aligned_t'(line_ext >> shamt);

	// ====================================================================
	// Redundant-group detection
	// ====================================================================

	// The record follows fetch advances only, a stall does not hold it
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= '0;
			prev_aligned <= '0;
		end else if (advance_fet_i) begin
			prev_pc <= pc_i;
			prev_aligned <= aligned_o;
		end
	end

	// Same address and same bits as last time means the group was already
	// sent down the pipe
	assign redundant_o = (prev_pc == pc_i) && (prev_aligned == aligned_o);

endmodule

//--- rtl/slot_builder.sv
// ====================================================================
// Cuts the aligned line into four instruction slots, applies the
// single-step, interrupt, stomp and branch-miss rules, and registers
// the resulting group for the decode stage.
// ====================================================================

`timescale 1ns/1ns

module slot_builder import fetch_mux_pkg::*; (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     en_i,
	input  logic     stall_i,
	input  pc_t      pc_i,
	input  aligned_t aligned_i,
	input  logic     redundant_i,
	input  logic     ssm_i,
	input  logic     nmi_i,
	input  logic     irq_i,
	input  logic     stomp_i,
	input  logic     branchmiss_i,
	input  pc_t      miss_pc_i,
	output group_t   group_o
);

	localparam int INSN_W = $bits(insn_t);

	// Register enable, held back by a stall
	logic en;

	// Single-step flag from the previous enabled cycle
	logic ssm_q;

	// First cycle of a single step lets exactly one instruction through
	logic first_step;

	// Interrupts and stomps kill the whole group
	logic kill_all;

	// PC of every slot
	pc_t slot_pc [NUM_SLOTS];

	group_t group_d;
	group_t group_q;

	assign en = en_i & ~stall_i;
	assign first_step = ssm_i & ~ssm_q;
	assign kill_all = nmi_i | irq_i | stomp_i;

	// ====================================================================
	// Slot construction
	// ====================================================================

	// Instructions are fixed length, so slot i sits 6*i bytes past the PC
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slot_pc[i] = pc_i + pc_t'(INSN_BYTES * i);
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			group_d[i].pc = slot_pc[i];
			group_d[i].insn = aligned_i[i*INSN_W +: INSN_W];
			group_d[i].ssm = 1'b0;
			group_d[i].valid = ~kill_all;

			// The same group was already issued on the last advance
			if (redundant_i) begin
				group_d[i].insn = NOP_INSN;
			end

			// Under single step only slot 0 of the first cycle survives,
			// everything else is marked as held back by the step
			if (ssm_i && (i != 0 || !first_step)) begin
				group_d[i].insn = NOP_INSN;
				group_d[i].ssm = 1'b1;
				group_d[i].valid = 1'b0;
			end

			// Instructions ahead of a mispredicted branch target are on the
			// wrong path and must not execute
			if (branchmiss_i && (slot_pc[i] < miss_pc_i)) begin
				group_d[i].insn = NOP_INSN;
				group_d[i].valid = 1'b0;
			end
		end
	end

	// ====================================================================
	// Group register
	// ====================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ssm_q <= 1'b0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				group_q[i].valid <= 1'b0;
				group_q[i].ssm <= 1'b0;
				group_q[i].pc <= '0;
				group_q[i].insn <= NOP_INSN;
			end
		end else if (en) begin
			ssm_q <= ssm_i;
			group_q <= group_d;
		end
	end

	assign group_o = group_q;

endmodule

//--- rtl/flow_detector.sv
// ====================================================================
// Scans a registered group for the first valid branch, call or return
// and works out the branch target and the return address.
// ====================================================================

`timescale 1ns/1ns

module flow_detector import fetch_mux_pkg::*; #(
	parameter pc_t RST_PC = 32'h0000_0000
) (
	input  group_t group_i,
	output flow_t  flow_o
);

	// Per-slot opcode and displacement fields
	opcode_t op [NUM_SLOTS];
	pc_t     disp [NUM_SLOTS];

	// Slot holds a valid flow-change instruction
	logic [NUM_SLOTS-1:0] hit;

	// ====================================================================
	// Per-slot decode
	// ====================================================================

	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			op[i] = group_i[i].insn[6:0];
			// The displacement is the top two parcels of the instruction
			disp[i] = group_i[i].insn[47:16];
			hit[i] = group_i[i].valid &&
				(op[i] inside {OP_BSR, OP_BRA, OP_JSR, OP_JSRR, OP_RET});
		end
	end

	// ====================================================================
	// Priority select
	// ====================================================================

	// Slot 0 is oldest, so the lowest slot with a hit wins and any flow
	// change behind it is on a path that will not be followed
	always_comb begin
		logic found;

		found = 1'b0;
		flow_o.do_branch = 1'b0;
		flow_o.do_call = 1'b0;
		flow_o.do_ret = 1'b0;
		flow_o.tgt = RST_PC;
		flow_o.ret_pc = RST_PC;

		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (hit[i] && !found) begin
				found = 1'b1;
				case (op[i])
					OP_BSR: begin
						flow_o.do_branch = 1'b1;
						flow_o.do_call = 1'b1;
						flow_o.tgt = group_i[i].pc + disp[i];
						flow_o.ret_pc = group_i[i].pc + pc_t'(INSN_BYTES);
					end
					OP_BRA: begin
						flow_o.do_branch = 1'b1;
						flow_o.tgt = group_i[i].pc + disp[i];
					end
					OP_JSR: begin
						flow_o.do_branch = 1'b1;
						flow_o.do_call = 1'b1;
						flow_o.tgt = disp[i];
						flow_o.ret_pc = group_i[i].pc + pc_t'(INSN_BYTES);
					end
					// Register call, the target comes from later in the pipe
					OP_JSRR: begin
						flow_o.do_call = 1'b1;
						flow_o.ret_pc = group_i[i].pc + pc_t'(INSN_BYTES);
					end
					OP_RET: begin
						flow_o.do_ret = 1'b1;
					end
					default: begin
						flow_o.do_branch = 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- rtl/fetch_mux_top.sv
// ====================================================================
// Fetch-to-decode mux stage. Takes a cache line and fetch PC, hands
// four registered instruction slots to decode one cycle later and
// reports the first flow change found in them.
// ====================================================================

`timescale 1ns/1ns

module fetch_mux_top import fetch_mux_pkg::*; #(
	parameter pc_t RST_PC = 32'hffff_fc00
) (
	input  logic   clk,
	input  logic   rst_i,
	input  logic   advance_fet_i,
	input  logic   en_i,
	input  logic   stall_i,
	input  line_t  line_i,
	input  pc_t    pc_i,
	input  logic   ssm_i,
	input  logic   nmi_i,
	input  logic   irq_i,
	input  logic   stomp_i,
	input  logic   branchmiss_i,
	input  pc_t    miss_pc_i,
	input  logic   flush_i,
	output group_t group_o,
	output flow_t  flow_o,
	output logic   flush_o,
	output logic   nop_o
);

	aligned_t aligned;
	logic     redundant;

	// Same enable as the slot registers, so side signals stay in step
	logic en;

	assign en = en_i & ~stall_i;

	line_aligner line_aligner_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.advance_fet_i (advance_fet_i),
		.line_i        (line_i),
		.pc_i          (pc_i),
		.aligned_o     (aligned),
		.redundant_o   (redundant)
	);

	slot_builder slot_builder_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.stall_i      (stall_i),
		.pc_i         (pc_i),
		.aligned_i    (aligned),
		.redundant_i  (redundant),
		.ssm_i        (ssm_i),
		.nmi_i        (nmi_i),
		.irq_i        (irq_i),
		.stomp_i      (stomp_i),
		.branchmiss_i (branchmiss_i),
		.miss_pc_i    (miss_pc_i),
		.group_o      (group_o)
	);

	flow_detector #(
		.RST_PC (RST_PC)
	) flow_detector_i (
		.group_i (group_o),
		.flow_o  (flow_o)
	);

	// Flush and stomp travel alongside the group they belong to
	always_ff @(posedge clk) begin
		if (rst_i) begin
			flush_o <= 1'b0;
			nop_o <= 1'b0;
		end else if (en) begin
			flush_o <= flush_i;
			nop_o <= stomp_i;
		end
	end

endmodule

//--- verif/fetch_mux_tb_tasks.svh
// ======================================================================
// Reference model, checkers and directed tests of the fetch mux
// testbench. Included inside the testbench module.
// ======================================================================

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step for every bit taken
task automatic take_random(input int n, output line_t v);
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v[k] = lfsr_q[0];
	end
endtask

function automatic insn_t make_insn(input opcode_t op, input logic [31:0] disp);
	return {disp, 9'd0, op};
endfunction

// Twelve parcels from the fetch parcel on with zero (a NOP) past the line end
function automatic aligned_t align_line(input line_t line, input pc_t pc);
	aligned_t a;
	int idx;
	a = '0;
	for (int j = 0; j < NUM_SLOTS * INSN_PARCELS; j++) begin
		idx = int'(pc[5:1]) + j;
		if (idx < 32) begin
			a[j*PARCEL_BITS +: PARCEL_BITS] = line[idx*PARCEL_BITS +: PARCEL_BITS];
		end
	end
	return a;
endfunction

// Expected registered group for one enabled cycle
function automatic group_t model_group(input line_t line, input pc_t pc, input ctl_t c,
		input pc_t miss_pc);
	group_t g;
	aligned_t a;
	logic redundant;
	a = align_line(line, pc);
	redundant = (pc == ref_prev_pc) && (a == ref_prev_aligned);
	for (int i = 0; i < NUM_SLOTS; i++) begin
		g[i].pc = pc + pc_t'(INSN_BYTES * i);
		g[i].insn = redundant ? NOP_INSN : a[i*$bits(insn_t) +: $bits(insn_t)];
		// Only slot 0 of the first step gets through
		g[i].ssm = c.ssm && (i > 0 || ref_ssm_q);
		if (g[i].ssm) begin
			g[i].insn = NOP_INSN;
		end
		g[i].valid = !(c.nmi || c.irq || c.stomp || g[i].ssm);
		if (c.branchmiss && g[i].pc < miss_pc) begin
			g[i].insn = NOP_INSN;
			g[i].valid = 1'b0;
		end
	end
	return g;
endfunction

// Expected flow result where the oldest valid flow instruction decides
function automatic flow_t model_flow(input group_t g);
	flow_t f;
	opcode_t op;
	logic found;
	f = {3'b000, RST_PC, RST_PC};
	found = 1'b0;
	for (int i = 0; i < NUM_SLOTS; i++) begin
		op = g[i].insn[6:0];
		if (!found && g[i].valid) begin
			if (op == OP_BRA || op == OP_BSR || op == OP_JSR) begin
				f.do_branch = 1'b1;
				f.tgt = (op == OP_JSR) ? g[i].insn[47:16] : g[i].pc + g[i].insn[47:16];
				found = 1'b1;
			end
			if (op == OP_BSR || op == OP_JSR || op == OP_JSRR) begin
				f.do_call = 1'b1;
				f.ret_pc = g[i].pc + pc_t'(INSN_BYTES);
				found = 1'b1;
			end
			if (op == OP_RET) begin
				f.do_ret = 1'b1;
				found = 1'b1;
			end
		end
	end
	return f;
endfunction

task automatic report_mismatch(input string name, input wide_t got, input wide_t exp);
	mismatch_count++;
	$display("Mismatch %s: got %0h, expected %0h", name, got, exp);
endtask

// ======================================================================
// Output checks
// ======================================================================

task automatic compare_outputs(input group_t exp, input logic exp_flush, input logic exp_nop);
	flow_t f;
	f = model_flow(exp);
	for (int i = 0; i < NUM_SLOTS; i++) begin
		assert ({group_o[i].valid, group_o[i].ssm} === {exp[i].valid, exp[i].ssm})
			else report_mismatch($sformatf("group_o[%0d].valid,ssm", i),
				wide_t'({group_o[i].valid, group_o[i].ssm}), wide_t'({exp[i].valid, exp[i].ssm}));
		assert (group_o[i].pc === exp[i].pc)
			else report_mismatch($sformatf("group_o[%0d].pc", i), group_o[i].pc, exp[i].pc);
		assert (group_o[i].insn === exp[i].insn)
			else report_mismatch($sformatf("group_o[%0d].insn", i), group_o[i].insn, exp[i].insn);
	end
	assert (flow_o === f) else report_mismatch("flow_o", flow_o, f);
	assert (flush_o === exp_flush) else report_mismatch("flush_o", flush_o, exp_flush);
	assert (nop_o === exp_nop) else report_mismatch("nop_o", nop_o, exp_nop);
endtask

// Presents one advance for a single enabled cycle and checks the result
task automatic run_group(input line_t line, input pc_t pc, input ctl_t c, input pc_t miss_pc);
	group_t exp;
	exp = model_group(line, pc, c, miss_pc);
	@(posedge clk);
	line_i <= line;
	pc_i <= pc;
	advance_fet_i <= 1'b1;
	en_i <= 1'b1;
	{ssm_i, nmi_i, irq_i, stomp_i, branchmiss_i, flush_i} <= c;
	miss_pc_i <= miss_pc;
	@(posedge clk);
	advance_fet_i <= 1'b0;
	en_i <= 1'b0;
	ref_prev_pc = pc;
	ref_prev_aligned = align_line(line, pc);
	ref_ssm_q = c.ssm;
	@(negedge clk);
	compare_outputs(exp, c.flush, c.stomp);
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic reset_and_extraction();
	group_t exp;
	line_t line;
	line_t r;
	for (int i = 0; i < NUM_SLOTS; i++) begin
		exp[i] = {1'b0, 1'b0, 32'h0, NOP_INSN};
	end
	@(negedge clk);
	compare_outputs(exp, 1'b0, 1'b0);
	// The first two PCs run the group past the line end
	for (int k = 0; k < 10; k++) begin
		take_random(512, line);
		take_random(32, r);
		run_group(line, (k == 0) ? 32'h0000_1030 : (k == 1) ? 32'h0000_203e
			: {r[31:1], 1'b0}, '0, '0);
	end
endtask

task automatic redundant_group();
	line_t line;
	take_random(512, line);
	run_group(line, 32'h0000_5012, '0, '0);
	run_group(line, 32'h0000_5012, '0, '0);
	for (int i = 0; i < NUM_SLOTS; i++) begin
		assert (group_o[i].insn === NOP_INSN)
			else report_mismatch("group_o.insn of repeat", group_o[i].insn, NOP_INSN);
	end
	run_group(~line, 32'h0000_5012, '0, '0);
endtask

task automatic single_step_sequence();
	line_t line;
	ctl_t c;
	c = '0;
	c.ssm = 1'b1;
	for (int k = 0; k < 3; k++) begin
		take_random(512, line);
		// Third group is sent after single stepping has ended
		run_group(line, 32'h0000_6000 + pc_t'(k * 24), (k < 2) ? c : '0, '0);
	end
endtask

task automatic invalidation_rules();
	line_t line;
	ctl_t c;
	pc_t pc;
	for (int k = 0; k < 3; k++) begin
		c = '0;
		c.nmi = (k == 0);
		c.irq = (k == 1);
		c.stomp = (k == 2);
		take_random(512, line);
		run_group(line, 32'h0000_7000 + pc_t'(k * 64), c, '0);
	end
	// Miss PC steps from below slot 0 to past slot 3
	c = '0;
	c.branchmiss = 1'b1;
	for (int k = 0; k < 5; k++) begin
		take_random(512, line);
		pc = 32'h0000_7100 + pc_t'(k * 64);
		run_group(line, pc, c, pc + pc_t'(6 * k) - 32'd1);
	end
endtask

task automatic flow_case(input opcode_t op0, input opcode_t op1, input opcode_t op2,
		input opcode_t op3, input ctl_t c);
	opcode_t ops [NUM_SLOTS];
	line_t line;
	line_t r;
	ops = '{op0, op1, op2, op3};
	line = '0;
	// The fetch PC points at parcel 3 of the line
	for (int s = 0; s < NUM_SLOTS; s++) begin
		take_random(32, r);
		line[(3 + 3 * s) * PARCEL_BITS +: 48] = make_insn(ops[s], r[31:0]);
	end
	run_group(line, 32'h0000_8006, c, 32'h0000_8006 + 32'd7);
endtask

task automatic flow_priority();
	ctl_t c;
	c = '0;
	flow_case(OP_BRA, OP_NOP, OP_NOP, OP_NOP, c);
	flow_case(OP_NOP, OP_BSR, OP_BRA, OP_RET, c);
	flow_case(7'h11, OP_NOP, OP_JSR, OP_BSR, c);
	flow_case(OP_NOP, OP_NOP, OP_JSRR, OP_RET, c);
	flow_case(OP_NOP, OP_NOP, OP_NOP, OP_RET, c);
	flow_case(7'h10, 7'h7f, OP_NOP, 7'h06, c);
	// Slots 0 and 1 lie below the miss PC, so the JSR in slot 2 wins
	c.branchmiss = 1'b1;
	flow_case(OP_BRA, OP_BSR, OP_JSR, OP_RET, c);
endtask

task automatic stall_hold();
	group_t held;
	group_t exp;
	line_t line;
	ctl_t c;
	int cycles;
	c = '0;
	c.stomp = 1'b1;
	c.flush = 1'b1;
	take_random(512, line);
	// The group that the stall must keep on the output
	held = model_group(line, 32'h0000_9000, c, '0);
	run_group(line, 32'h0000_9000, c, '0);
	for (int k = 0; k < 4; k++) begin
		take_random(512, line);
		@(posedge clk);
		line_i <= line;
		pc_i <= 32'h0000_9100 + pc_t'(k * 16);
		{en_i, stall_i, flush_i, stomp_i} <= 4'b1100;
		@(negedge clk);
		assert (group_o === held) else report_mismatch("group_o under stall", group_o, held);
		assert ({flush_o, nop_o} === 2'b11)
			else report_mismatch("flush_o,nop_o under stall", {flush_o, nop_o}, 2'b11);
	end
	// Release the stall with a new advance and a flush
	take_random(512, line);
	c = '0;
	c.flush = 1'b1;
	exp = model_group(line, 32'h0000_9200, c, '0);
	@(posedge clk);
	stall_i <= 1'b0;
	line_i <= line;
	pc_i <= 32'h0000_9200;
	advance_fet_i <= 1'b1;
	flush_i <= 1'b1;
	@(posedge clk);
	{en_i, advance_fet_i, flush_i} <= 3'b000;
	ref_prev_pc = 32'h0000_9200;
	ref_prev_aligned = align_line(line, 32'h0000_9200);
	cycles = 0;
	do begin
		@(negedge clk);
		cycles++;
	end while (group_o[0].pc !== 32'h0000_9200 && cycles < 8);
	assert (group_o[0].pc === 32'h0000_9200) else begin
		failure_count++;
		$display("The group sent after the stall never reached the output");
	end
	if (group_o[0].pc === 32'h0000_9200) begin
		assert (cycles == 1) else report_mismatch("group latency", wide_t'(cycles), 1);
		compare_outputs(exp, 1'b1, 1'b0);
	end
endtask

//--- verif/fetch_mux_tb.sv
// ======================================================================
// Testbench for the fetch mux stage. Runs the directed tests from the
// included task file against the DUT and prints the error counts.
// ======================================================================

`timescale 1ns/1ns

module fetch_mux_tb import fetch_mux_pkg::*; ();

	localparam pc_t RST_PC = 32'hffff_fc00;
	localparam int TIMEOUT_CYCLES = 5000;

	// Control inputs that change together in one test step
	typedef struct packed {
		logic ssm;
		logic nmi;
		logic irq;
		logic stomp;
		logic branchmiss;
		logic flush;
	} ctl_t;

	// Wide enough for any value shown in a mismatch line
	typedef logic [511:0] wide_t;

	logic   clk;
	logic   rst_i;
	logic   advance_fet_i;
	logic   en_i;
	logic   stall_i;
	line_t  line_i;
	pc_t    pc_i;
	logic   ssm_i;
	logic   nmi_i;
	logic   irq_i;
	logic   stomp_i;
	logic   branchmiss_i;
	pc_t    miss_pc_i;
	logic   flush_i;
	group_t group_o;
	flow_t  flow_o;
	logic   flush_o;
	logic   nop_o;

	int mismatch_count;
	int failure_count;
	logic [31:0] lfsr_q;

	// Model copies of the fetch record and of the stored single-step flag
	pc_t      ref_prev_pc;
	aligned_t ref_prev_aligned;
	logic     ref_ssm_q;

	fetch_mux_top #(
		.RST_PC (RST_PC)
	) fetch_mux_top_i (.*);

	`include "fetch_mux_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog so that a stuck test cannot run forever
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rst_i <= 1'b1;
		advance_fet_i <= 1'b0;
		en_i <= 1'b0;
		stall_i <= 1'b0;
		line_i <= '0;
		pc_i <= '0;
		{ssm_i, nmi_i, irq_i, stomp_i, branchmiss_i, flush_i} <= '0;
		miss_pc_i <= '0;
		mismatch_count = 0;
		failure_count = 0;
		lfsr_q = 32'hca5d_16e8;
		// The DUT clears its fetch record and step flag in reset
		ref_prev_pc = '0;
		ref_prev_aligned = '0;
		ref_ssm_q = 1'b0;
		repeat (10) @(posedge clk);
		rst_i <= 1'b0;

		reset_and_extraction();
		redundant_group();
		single_step_sequence();
		invalidation_rules();
		flow_priority();
		stall_hold();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- fetch_mux_top.f
+incdir+verif
rtl/fetch_mux_pkg.sv
rtl/line_aligner.sv
rtl/slot_builder.sv
rtl/flow_detector.sv
rtl/fetch_mux_top.sv
verif/fetch_mux_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch mux testbench with Verilator, runs it and scans the log.
# Exits non-zero when the build fails, the run fails or a check failed.

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f fetch_mux_top.f \
	--top-module fetch_mux_tb \
	-o fetch_mux_sim &&
./obj_dir/fetch_mux_sim > "$LOG" 2>&1 ||
{ cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "RESULT: FAIL" "$LOG" && exit 1
grep -q "RESULT: PASS" "$LOG" || exit 1
exit 0
